//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := roll_tb
FILELIST := sources.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/beat_ram.sv
`timescale 1ns/100ps

module beat_ram (
  input  logic                        clk,
  input  roll_pkg::wr_req_t           wr,
  input  logic [roll_pkg::ADDR_W-1:0] rd_addr,
  output roll_pkg::beat_t             rd_data
);

  import roll_pkg::*;

  // One block of beats
  beat_t mem [MAX_BEATS];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Registered read, one cycle latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- design/roll_addr_decode.sv
`timescale 1ns/100ps

module roll_addr_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [roll_pkg::DIST_W-1:0] roll_distance,
  input  logic [roll_pkg::CNT_W-1:0]  block_size,
  input  logic                        first_beat,
  input  logic                        accept,
  output logic [roll_pkg::ADDR_W-1:0] wr_addr
);

  import roll_pkg::*;

  logic [CNT_W-1:0]  n_q;
  logic [CNT_W-1:0]  n_cur;
  logic [CNT_W-1:0]  residue;
  logic [ADDR_W-1:0] addr_q;
  logic              at_end;

  // Distance reduced modulo the block length
  // A zero size is illegal and caught by the check below
  assign residue = (block_size == '0) ? '0 : CNT_W'(roll_distance % block_size);

  // First beat lands at the residue without waiting a cycle
  assign wr_addr = first_beat ? residue[ADDR_W-1:0] : addr_q;

  // Block length of the beat being written
  assign n_cur = first_beat ? block_size : n_q;

  // Wrap point of the rotated address
  assign at_end = (CNT_W'(wr_addr) == n_cur - CNT_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      n_q    <= '0;
      addr_q <= '0;
    end else begin
      if (first_beat) begin
        n_q <= block_size;
      end
      if (accept) begin
        addr_q <= at_end ? '0 : wr_addr + ADDR_W'(1);
      end
    end
  end

  // Block length must fit the beat RAM
  a_block_size_legal: assert property (
    @(posedge clk) disable iff (rst)
    first_beat |-> (block_size != '0) && (block_size <= CNT_W'(MAX_BEATS))
  ) else $error("block_size %0d out of range on first beat", block_size);

endmodule

//--- design/roll_execute.sv
`timescale 1ns/100ps

module roll_execute (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [roll_pkg::CNT_W-1:0]  block_size,
  input  roll_pkg::beat_t             in_beat,
  input  logic                        in_valid,
  input  logic [roll_pkg::ADDR_W-1:0] wr_addr,
  input  logic                        skid_full,
  output logic                        in_ready,
  output logic                        first_beat,
  output logic                        accept,
  output roll_pkg::rd_beat_t          rd_out,
  output logic                        rd_issue
);

  import roll_pkg::*;

  typedef enum logic {
    FILL,
    DRAIN
  } state_t;

  state_t            state;
  logic [CNT_W-1:0]  wr_cnt;
  logic [CNT_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  n_q;
  logic [CNT_W-1:0]  n_cur;
  logic              last_write;
  logic              last_read;
  logic              last_q;
  logic [ADDR_W-1:0] rd_addr;
  wr_req_t           wr_req;
  beat_t             rd_data;

  // Input side
  assign in_ready   = (state == FILL);
  assign accept     = in_valid && in_ready;
  assign first_beat = accept && (wr_cnt == '0);

  // Block size taken live on the first beat and latched after
  assign n_cur      = first_beat ? block_size : n_q;
  assign last_write = (wr_cnt == n_cur - CNT_W'(1));

  // Every accepted beat goes to its rotated slot
  always_comb begin
    wr_req.en   = accept;
    wr_req.addr = wr_addr;
    wr_req.data = in_beat;
  end

  // Reads walk the block in output order and stall on a full skid stage
  assign rd_issue  = (state == DRAIN) && !skid_full;
  assign rd_addr   = rd_ptr[ADDR_W-1:0];
  assign last_read = (rd_ptr == n_q - CNT_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= FILL;
      wr_cnt <= '0;
      rd_ptr <= '0;
      n_q    <= '0;
      last_q <= 1'b0;
    end else begin
      // Last marker follows the RAM read latency
      last_q <= rd_issue && last_read;
      if (first_beat) begin
        n_q <= block_size;
      end
      case (state)
        FILL: begin
          if (accept) begin
            if (last_write) begin
              wr_cnt <= '0;
              state  <= DRAIN;
            end else begin
              wr_cnt <= wr_cnt + CNT_W'(1);
            end
          end
        end
        DRAIN: begin
          // Back to fill as soon as the final read is out
          if (rd_issue) begin
            if (last_read) begin
              rd_ptr <= '0;
              state  <= FILL;
            end else begin
              rd_ptr <= rd_ptr + CNT_W'(1);
            end
          end
        end
        default: state <= FILL;
      endcase
    end
  end

  beat_ram u_ram (
    .clk     (clk),
    .wr      (wr_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  assign rd_out.data = rd_data;
  assign rd_out.last = last_q;

  // Rotated write address stays inside the block being filled
  a_write_in_block: assert property (
    @(posedge clk) disable iff (rst)
    wr_req.en |-> (CNT_W'(wr_req.addr) < n_cur)
  ) else $error("RAM write at %0d outside block of %0d", wr_req.addr, n_cur);

  // Reads stay inside the block
  a_read_legal: assert property (
    @(posedge clk) disable iff (rst)
    rd_issue |-> (rd_ptr < n_q)
  ) else $error("illegal read issue, rd_ptr %0d n %0d", rd_ptr, n_q);

endmodule

//--- design/roll_pkg.sv
package roll_pkg;

  // Block geometry
  localparam int MAX_BEATS = 16;
  localparam int LANES     = 4;
  localparam int LANE_W    = 16;

  // RAM address covers one full block
  localparam int ADDR_W = $clog2(MAX_BEATS);

  // One extra bit so a count of MAX_BEATS fits
  localparam int CNT_W = ADDR_W + 1;

  // Distance may be larger than the block and is reduced modulo n
  localparam int DIST_W = 5;

  // One fixed-point lane
  typedef logic [LANE_W-1:0] lane_t;

  // One beat, lane 0 in the low bits
  typedef lane_t [LANES-1:0] beat_t;

  // RAM write request
  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    beat_t             data;
  } wr_req_t;

  // Beat read back from the RAM or held in the output stage
  typedef struct packed {
    beat_t data;
    // Final beat of a block
    logic  last;
  } rd_beat_t;

endpackage

//--- design/roll_result.sv
`timescale 1ns/100ps

module roll_result (
  input  logic               clk,
  input  logic               rst,
  input  roll_pkg::rd_beat_t rd_in,
  input  logic               rd_issue,
  input  logic               out_ready,
  output logic               skid_full,
  output roll_pkg::beat_t    out_beat,
  output logic               out_valid,
  output logic               done
);

  import roll_pkg::*;

  // RAM data is valid one cycle after the read
  logic     rd_valid_q;
  // Output and extra register
  rd_beat_t out_q, out_d;
  rd_beat_t ext_q, ext_d;
  logic     out_v, out_v_d;
  logic     ext_v, ext_v_d;
  // Extra register holds the older beat
  logic     sel, sel_d;
  rd_beat_t cur;
  logic     fire;

  // Present the older beat
  assign cur       = sel ? ext_q : out_q;
  assign out_valid = sel ? ext_v : out_v;
  assign out_beat  = cur.data;
  assign fire      = out_valid && out_ready;
  assign done      = fire && cur.last;

  // Room for one more read only if nothing would overflow a cycle later
  assign skid_full = (out_v && ext_v) || ((out_v || ext_v) && !out_ready);

  always_comb begin
    out_d   = out_q;
    ext_d   = ext_q;
    out_v_d = out_v;
    ext_v_d = ext_v;
    sel_d   = sel;
    // Retire the presented beat
    if (fire) begin
      if (sel) begin
        ext_v_d = 1'b0;
        sel_d   = 1'b0;
      end else begin
        out_v_d = 1'b0;
        sel_d   = ext_v;
      end
    end
    // Land the RAM beat in whichever register is free
    if (rd_valid_q) begin
      if (out_v_d) begin
        ext_d   = rd_in;
        ext_v_d = 1'b1;
      end else begin
        out_d   = rd_in;
        out_v_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_q <= 1'b0;
      out_v      <= 1'b0;
      ext_v      <= 1'b0;
      sel        <= 1'b0;
    end else begin
      rd_valid_q <= rd_issue;
      out_v      <= out_v_d;
      ext_v      <= ext_v_d;
      sel        <= sel_d;
    end
  end

  always_ff @(posedge clk) begin
    out_q <= out_d;
    ext_q <= ext_d;
  end

  // Stalled output holds its beat
  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat)
  ) else $error("out_beat changed or dropped without a transfer");

  // Read pacing upstream never lands a beat on a full stage
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    rd_valid_q |-> !(out_v && ext_v && !fire)
  ) else $error("skid stage overflow");

endmodule

//--- design/roll_top.sv
`timescale 1ns/100ps

module roll_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [roll_pkg::DIST_W-1:0] roll_distance,
  input  logic [roll_pkg::CNT_W-1:0]  block_size,
  input  roll_pkg::beat_t             in_beat,
  input  logic                        in_valid,
  output logic                        in_ready,
  output roll_pkg::beat_t             out_beat,
  output logic                        out_valid,
  input  logic                        out_ready,
  output logic                        done
);

  import roll_pkg::*;

  logic              first_beat;
  logic              accept;
  logic [ADDR_W-1:0] wr_addr;
  rd_beat_t          rd_beat;
  logic              rd_issue;
  logic              skid_full;

  roll_addr_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .roll_distance (roll_distance),
    .block_size    (block_size),
    .first_beat    (first_beat),
    .accept        (accept),
    .wr_addr       (wr_addr)
  );

  roll_execute u_execute (
    .clk        (clk),
    .rst        (rst),
    .block_size (block_size),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .wr_addr    (wr_addr),
    .skid_full  (skid_full),
    .in_ready   (in_ready),
    .first_beat (first_beat),
    .accept     (accept),
    .rd_out     (rd_beat),
    .rd_issue   (rd_issue)
  );

  roll_result u_result (
    .clk       (clk),
    .rst       (rst),
    .rd_in     (rd_beat),
    .rd_issue  (rd_issue),
    .out_ready (out_ready),
    .skid_full (skid_full),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .done      (done)
  );

endmodule

//--- sim/roll_checker.sv
`timescale 1ns/100ps

module roll_checker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [roll_pkg::DIST_W-1:0] roll_distance,
  input  logic [roll_pkg::CNT_W-1:0]  block_size,
  input  int                          table_shift,
  input  roll_pkg::beat_t             in_beat,
  input  logic                        in_valid,
  input  logic                        in_ready,
  input  roll_pkg::beat_t             out_beat,
  input  logic                        out_valid,
  input  logic                        out_ready,
  input  logic                        done,
  input  logic                        end_check,
  input  int                          expected_blocks,
  output int                          data_errors,
  output int                          done_errors,
  output int                          other_errors,
  output int                          out_count,
  output logic                        final_done
);

  import roll_pkg::*;

  // Beats of the block being filled
  beat_t blk [$];
  // Expected output stream, oldest first
  beat_t exp_data [$];
  logic  exp_last [$];
  int    cur_n;
  int    cur_shift;
  int    block_count;
  int    done_count;
  // Input beats taken while older output was still pending
  int    overlap_count;
  logic  after_reset;
  beat_t want_data;
  logic  want_last;

  // Output j takes input (j - shift) mod n
  task automatic close_block();
    for (int j = 0; j < cur_n; j++) begin
      exp_data.push_back(blk[(j - cur_shift + cur_n) % cur_n]);
      exp_last.push_back(j == cur_n - 1);
    end
    blk.delete();
    block_count++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      blk.delete();
      exp_data.delete();
      exp_last.delete();
      data_errors   = 0;
      done_errors   = 0;
      other_errors  = 0;
      out_count     = 0;
      block_count   = 0;
      done_count    = 0;
      overlap_count = 0;
      cur_n         = 1;
      cur_shift     = 0;
      after_reset   = 1'b1;
      final_done    = 1'b0;
    end else begin
      // Idle state right after reset, before any stimulus
      if (after_reset) begin
        after_reset = 1'b0;
        if (out_valid !== 1'b0) begin
          other_errors++;
          $display("FAILED t=%0t out_valid expected 0 got %b", $time, out_valid);
        end
        if (done !== 1'b0) begin
          other_errors++;
          $display("FAILED t=%0t done expected 0 got %b", $time, done);
        end
        if (in_ready !== 1'b1) begin
          other_errors++;
          $display("FAILED t=%0t in_ready expected 1 got %b", $time, in_ready);
        end
      end

      if (in_valid && in_ready) begin
        // Config is sampled with the first beat
        if (blk.size() == 0) begin
          cur_n     = int'(block_size);
          cur_shift = table_shift;
          if (cur_shift != int'(roll_distance) % cur_n) begin
            other_errors++;
            $display("Table shift %0d does not equal distance %0d modulo %0d",
                     cur_shift, roll_distance, cur_n);
          end
        end
        if (out_valid && exp_data.size() != 0) begin
          overlap_count++;
        end
        blk.push_back(in_beat);
        if (blk.size() == cur_n) begin
          close_block();
        end
      end

      if (out_valid && out_ready) begin
        out_count++;
        if (exp_data.size() == 0) begin
          other_errors++;
          $display("Output beat at %0t arrived while no beat was expected", $time);
        end else begin
          want_data = exp_data.pop_front();
          want_last = exp_last.pop_front();
          if (out_beat !== want_data) begin
            data_errors++;
            $display("FAILED t=%0t out_beat expected %h got %h", $time, want_data, out_beat);
          end
          if (done !== want_last) begin
            done_errors++;
            $display("FAILED t=%0t done expected %b got %b", $time, want_last, done);
          end
        end
      end else if (done !== 1'b0) begin
        done_errors++;
        $display("FAILED t=%0t done expected 0 got %b", $time, done);
      end
      if (done === 1'b1) begin
        done_count++;
      end

      // End of run bookkeeping
      if (end_check && !final_done) begin
        final_done = 1'b1;
        if (exp_data.size() != 0 || blk.size() != 0) begin
          other_errors++;
          $display("%0d expected beats never came out, %0d beats left in an open block",
                   exp_data.size(), blk.size());
        end
        if (block_count != expected_blocks) begin
          other_errors++;
          $display("Saw %0d complete input blocks but the table has %0d",
                   block_count, expected_blocks);
        end
        if (done_count != expected_blocks) begin
          other_errors++;
          $display("done pulsed %0d times for %0d blocks", done_count, expected_blocks);
        end
        if (overlap_count == 0) begin
          other_errors++;
          $display("No input beat was accepted while older output was still pending");
        end
      end
    end
  end

endmodule

//--- sim/roll_tb.sv
`timescale 1ns/100ps

module roll_tb;

  import roll_pkg::*;

  localparam logic [31:0] SEED = 32'h171a;

  // One block of the stimulus table, shift is d mod n worked out by hand
  typedef struct packed {
    int   n;
    int   d;
    int   shift;
    logic rnd;
  } entry_t;

  logic              clk;
  logic              rst;
  logic [DIST_W-1:0] roll_distance;
  logic [CNT_W-1:0]  block_size;
  beat_t             in_beat;
  logic              in_valid;
  logic              in_ready;
  beat_t             out_beat;
  logic              out_valid;
  logic              out_ready;
  logic              done;

  entry_t blocks [$];
  int     num_blocks;
  int     table_shift;
  logic   rnd_ready;
  logic   end_check;
  int     data_errors;
  int     done_errors;
  int     other_errors;
  int     out_count;
  logic   final_done;

  roll_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .roll_distance (roll_distance),
    .block_size    (block_size),
    .in_beat       (in_beat),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .out_beat      (out_beat),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .done          (done)
  );

  roll_checker u_chk (
    .clk             (clk),
    .rst             (rst),
    .roll_distance   (roll_distance),
    .block_size      (block_size),
    .table_shift     (table_shift),
    .in_beat         (in_beat),
    .in_valid        (in_valid),
    .in_ready        (in_ready),
    .out_beat        (out_beat),
    .out_valid       (out_valid),
    .out_ready       (out_ready),
    .done            (done),
    .end_check       (end_check),
    .expected_blocks (num_blocks),
    .data_errors     (data_errors),
    .done_errors     (done_errors),
    .other_errors    (other_errors),
    .out_count       (out_count),
    .final_done      (final_done)
  );

  task automatic add_entry(input int n, input int d, input int shift, input logic rnd);
    entry_t e;
    e.n     = n;
    e.d     = d;
    e.shift = shift;
    e.rnd   = rnd;
    blocks.push_back(e);
  endtask

  task automatic load_table();
    // Identity and single beat
    add_entry(8, 0, 0, 1'b0);
    add_entry(1, 7, 0, 1'b0);
    // Full and odd sized rotations
    add_entry(16, 5, 5, 1'b0);
    add_entry(16, 15, 15, 1'b1);
    add_entry(5, 2, 2, 1'b0);
    // Distance at or past the block length
    add_entry(6, 6, 0, 1'b0);
    add_entry(6, 13, 1, 1'b1);
    // Back to back with config changes and output stalls
    add_entry(8, 3, 3, 1'b1);
    add_entry(1, 0, 0, 1'b1);
    add_entry(12, 31, 7, 1'b1);
    add_entry(16, 16, 0, 1'b0);
    add_entry(3, 1, 1, 1'b1);
  endtask

  function automatic int total_beats();
    int sum;
    sum = 0;
    foreach (blocks[i]) begin
      sum += blocks[i].n;
    end
    return sum;
  endfunction

  function automatic beat_t random_beat();
    return {$urandom, $urandom};
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Sink side, ready follows the mode of the block being fed
  initial begin
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      out_ready <= rnd_ready ? ($urandom_range(1, 0) == 32'd1) : 1'b1;
    end
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    @(negedge rst);
    limit = total_beats() * 2 * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles after reset", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    entry_t e;
    int     errors;
    void'($urandom(SEED));
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_beat       = '0;
    block_size    = CNT_W'(1);
    roll_distance = '0;
    table_shift   = 0;
    rnd_ready     = 1'b0;
    end_check     = 1'b0;
    load_table();
    num_blocks = blocks.size();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    for (int i = 0; i < blocks.size(); i++) begin
      e = blocks[i];
      rnd_ready <= e.rnd;
      for (int k = 0; k < e.n; k++) begin
        // Occasional idle cycles on the input
        while ($urandom_range(3, 0) == 0) begin
          in_valid <= 1'b0;
          @(posedge clk);
        end
        block_size    <= CNT_W'(e.n);
        roll_distance <= DIST_W'(e.d);
        table_shift   <= e.shift;
        in_beat       <= random_beat();
        in_valid      <= 1'b1;
        @(posedge clk);
        while (!in_ready) begin
          @(posedge clk);
        end
      end
    end
    in_valid <= 1'b0;

    wait (out_count >= total_beats());
    repeat (10) @(posedge clk);
    end_check <= 1'b1;
    wait (final_done);

    errors = data_errors + done_errors + other_errors;
    $display("Checked %0d output beats: %0d data errors, %0d done errors, %0d other errors",
             out_count, data_errors, done_errors, other_errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
design/roll_pkg.sv
design/roll_addr_decode.sv
design/beat_ram.sv
design/roll_execute.sv
design/roll_result.sv
design/roll_top.sv
sim/roll_checker.sv
sim/roll_tb.sv
